// ==== haar_integral.f ====
common/haar_pkg.sv
line_row/line_fifo.sv
line_row/line_row.sv
design/integral_window.sv
design/haar_integral_top.sv
testbench/tb_haar_integral.sv

// ==== testbench/tb_haar_integral.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_haar_integral
	import haar_pkg::*;
();

	// ~~~~~~~~~~~~~~~~~~~~
	// Geometry and test sizes.
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int FRAME_W     = 10;
	localparam int WIN_W       = 3;
	localparam int WIN_H       = 3;
	localparam int PRIME_COUNT = (WIN_H - 1) * FRAME_W + WIN_W;
	localparam int N_PRIME     = 40;
	localparam int N_GAPS      = 60;
	localparam int N_WHITE     = 30;
	localparam int N_PRE_SOF   = 10;
	localparam int N_POST_SOF  = 40;
	// Gaps test allows up to two idles per sample.
	localparam int STIM_CYCLES = 4 + 20 + (N_PRIME + 2) + (3 * N_GAPS + 2) + (N_WHITE + 2)
		+ (N_PRE_SOF + 1 + 1 + N_POST_SOF + 2);
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

	logic                   clk;
	logic                   reset;
	logic                   valid;
	pix_beat_t              beat;
	sum_t [WIN_W*WIN_H-1:0] window;
	logic                   window_valid;

	// Record of accepted samples since reset.
	pix_t pix_rec [$];
	bit   exp_pulse [$];
	int   model_cnt;

	logic [31:0] rng;
	string       cur_test;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	int          pulse_count;
	int          cycle_count;

	haar_integral_top #(
		.FRAME_W (FRAME_W),
		.WIN_W   (WIN_W),
		.WIN_H   (WIN_H)
	) UUT (
		.i_clk          (clk),
		.reset          (reset),
		.i_valid        (valid),
		.i_beat         (beat),
		.o_window       (window),
		.o_window_valid (window_valid)
	);

	// 8 ns clock.
	initial
	begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Samples before reset read as zero.
	function automatic pix_t pix_at(input int i);
		if (i < 0)
			return '0;
		return pix_rec[i];
	endfunction

	// Integral at (r, c) of the window after sample n.
	function automatic sum_t ref_integral(input int n, input int r, input int c);
		sum_t acc;
		int   rr;
		int   cc;
		acc = '0;
		for (rr = 0; rr <= r; rr++)
			for (cc = 0; cc <= c; cc++)
				acc += sum_t'(pix_at(n - (WIN_W - 1 - cc) - (WIN_H - 1 - rr) * FRAME_W));
		return acc;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Error reporting.
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic note_mismatch(input string what, input int exp, input int act);
		$display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		errors++;
		test_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		errors++;
		test_errors++;
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0)
		begin
			$display("test %s: passed", cur_test);
		end
		else
		begin
			$display("test %s: %0d errors", cur_test, test_errors);
			tests_failed++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers.
	// ~~~~~~~~~~~~~~~~~~~~

	// One accepted sample, with the expected pulse from the count rule.
	task automatic drive_beat(input pix_t pix, input logic sof);
		valid     = 1'b1;
		beat.sof  = sof;
		beat.data = pix;
		pix_rec.push_back(pix);
		if (sof)
			model_cnt = 1;
		else if (model_cnt < PRIME_COUNT)
			model_cnt++;
		exp_pulse.push_back(model_cnt >= PRIME_COUNT);
		@(posedge clk);
		#1;
	endtask

	task automatic drive_idle();
		valid    = 1'b0;
		beat.sof = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic drive_random(input logic sof);
		rng = xorshift32(rng);
		drive_beat(rng[7:0], sof);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Compare process.
	// ~~~~~~~~~~~~~~~~~~~~

	// Every window entry against the reference after sample n.
	task automatic check_window(input int n, input string tag);
		sum_t exp_val;
		for (int r = 0; r < WIN_H; r++)
		begin
			for (int c = 0; c < WIN_W; c++)
			begin
				exp_val = ref_integral(n, r, c);
				assert (window[r*WIN_W+c] === exp_val)
				else note_mismatch($sformatf("%s (%0d,%0d)", tag, r, c),
					exp_val, window[r*WIN_W+c]);
			end
		end
	endtask

	initial
	begin : compare
		logic was_valid;
		int   was_idx;
		forever
		begin
			@(posedge clk);
			was_valid = valid;
			was_idx   = pix_rec.size() - 1;
			// Outputs settle well before the falling edge.
			@(negedge clk);
			if (window_valid === 1'b1)
				pulse_count++;
			if (was_valid)
			begin
				assert (window_valid === exp_pulse[was_idx])
				else note_mismatch("window valid", exp_pulse[was_idx], window_valid);
				if (exp_pulse[was_idx])
				begin
					check_window(was_idx, "entry");
				end
			end
			else
			begin
				assert (window_valid === 1'b0)
				else note_failure("window valid pulsed after a cycle without a sample");
				// Held window still shows the last accepted sample.
				if (was_idx >= 0)
				begin
					check_window(was_idx, "held entry");
				end
			end
		end
	end

	// Run limit.
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin : stimulus
		int pulses_before;
		reset        = 1'b1;
		valid        = 1'b0;
		beat         = '0;
		rng          = 32'hf1e3_022e;
		model_cnt    = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		pulse_count  = 0;
		cycle_count  = 0;

		// Reset for 4 cycles, then quiet.
		start_test("reset_quiet");
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (20) drive_idle();
		end_test();

		// Back-to-back samples from reset.
		start_test("priming");
		pulses_before = pulse_count;
		repeat (N_PRIME) drive_random(1'b0);
		repeat (2) drive_idle();
		assert (pulse_count - pulses_before == N_PRIME - PRIME_COUNT + 1)
		else note_mismatch("pulse count", N_PRIME - PRIME_COUNT + 1, pulse_count - pulses_before);
		end_test();

		// Random idle cycles between samples.
		start_test("gaps");
		for (int i = 0; i < N_GAPS; i++)
		begin
			rng = xorshift32(rng);
			repeat (rng % 3) drive_idle();
			drive_random(1'b0);
		end
		repeat (2) drive_idle();
		end_test();

		// Full-scale pixels fill the whole window.
		start_test("sum_range");
		repeat (N_WHITE) drive_beat(8'd255, 1'b0);
		repeat (2) drive_idle();
		assert (window[WIN_W*WIN_H-1] === sum_t'(WIN_W * WIN_H * 255))
		else note_mismatch("bottom-right entry", WIN_W * WIN_H * 255, window[WIN_W*WIN_H-1]);
		end_test();

		// Frame restart mid-stream.
		start_test("frame_restart");
		repeat (N_PRE_SOF) drive_random(1'b0);
		drive_idle();
		pulses_before = pulse_count;
		drive_random(1'b1);
		repeat (N_POST_SOF) drive_random(1'b0);
		repeat (2) drive_idle();
		assert (pulse_count - pulses_before == N_POST_SOF + 1 - PRIME_COUNT + 1)
		else note_mismatch("pulses after sof", N_POST_SOF + 2 - PRIME_COUNT,
			pulse_count - pulses_before);
		end_test();

		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/haar_integral_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module haar_integral_top
	import haar_pkg::*;
#(
	// Line length in pixels.
	parameter int FRAME_W = 10,
	// Window size.
	parameter int WIN_W   = 3,
	parameter int WIN_H   = 3
)
(
	input  wire logic       i_clk,
	input  wire logic       reset,
	input  wire logic       i_valid,
	input  wire pix_beat_t  i_beat,
	output sum_t [WIN_W*WIN_H-1:0] o_window,
	output logic                   o_window_valid
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Window generator.
	// ~~~~~~~~~~~~~~~~~~~~

	// Entry r*WIN_W+c is the integral at row r, column c.
	integral_window #(
		.FRAME_W (FRAME_W),
		.WIN_W   (WIN_W),
		.WIN_H   (WIN_H)
	) u_window (
		.i_clk          (i_clk),
		.reset          (reset),
		.i_valid        (i_valid),
		.i_beat         (i_beat),
		.o_window       (o_window),
		.o_window_valid (o_window_valid)
	);

endmodule

`default_nettype wire

// ==== design/integral_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module integral_window
	import haar_pkg::*;
#(
	parameter int FRAME_W = 10,
	parameter int WIN_W   = 3,
	parameter int WIN_H   = 3
)
(
	input  wire logic       i_clk,
	input  wire logic       reset,
	input  wire logic       i_valid,
	input  wire pix_beat_t  i_beat,
	output sum_t [WIN_W*WIN_H-1:0] o_window,
	output logic                   o_window_valid
);

	// Samples needed before the oldest row holds real data.
	localparam int PRIME_COUNT = (WIN_H - 1) * FRAME_W + WIN_W;
	localparam int CNT_W = $clog2(PRIME_COUNT + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(PRIME_COUNT);

	// Pixel chain, entry k feeds chain row k.
	pix_t pix_chain [WIN_H+1];
	// Column sums, entry k leaves chain row k.
	sum_t col_chain [WIN_H+1];
	// Row integrals in chain order.
	sum_t [WIN_W-1:0] row_int [WIN_H];
	// Window in output order, before the register.
	sum_t [WIN_W*WIN_H-1:0] window_d;

	ctl_state_t       state;
	ctl_state_t       state_next;
	logic [CNT_W-1:0] sample_cnt;
	logic [CNT_W-1:0] cnt_next;

	// ~~~~~~~~~~~~~~~~~~~~
	// Row chain.
	// ~~~~~~~~~~~~~~~~~~~~

	// Newest line enters at row 0.
	assign pix_chain[0] = i_beat.data;
	// Oldest row has nothing below it.
	assign col_chain[WIN_H] = '0;

	for (genvar k = 0; k < WIN_H; k++)
	begin : g_row
		line_row #(
			.FRAME_W (FRAME_W),
			.WIN_W   (WIN_W)
		) u_row (
			.i_clk          (i_clk),
			.reset          (reset),
			.i_accept       (i_valid),
			.i_pix          (pix_chain[k]),
			.i_col_below    (col_chain[k+1]),
			.o_pix_delayed  (pix_chain[k+1]),
			.o_col_sum      (col_chain[k]),
			.o_row_integral (row_int[k])
		);
	end

	// Oldest chain row is window row 0.
	always_comb
	begin
		for (int r = 0; r < WIN_H; r++)
			window_d[r*WIN_W +: WIN_W] = row_int[WIN_H-1-r];
	end

	// Window register, held across idle cycles.
	always_ff @(posedge i_clk)
	begin
		if (i_valid)
			o_window <= window_d;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Priming controller.
	// ~~~~~~~~~~~~~~~~~~~~

	// sof counts as sample one; saturate once primed.
	always_comb
	begin
		if (i_beat.sof)
			cnt_next = CNT_W'(1);
		else if (sample_cnt == CNT_FULL)
			cnt_next = sample_cnt;
		else
			cnt_next = sample_cnt + 1'b1;
	end

	always_comb
	begin
		state_next = state;
		if (i_valid)
		begin
			case (state)
				ST_IDLE:
					state_next = ST_PRIME;
				ST_PRIME:
					if (cnt_next == CNT_FULL)
						state_next = ST_RUN;
				ST_RUN:
					if (i_beat.sof)
						state_next = ST_PRIME;
				default:
					state_next = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (reset)
		begin
			state          <= ST_IDLE;
			sample_cnt     <= '0;
			o_window_valid <= 1'b0;
		end
		else
		begin
			state          <= state_next;
			// One pulse per accepted sample while running.
			o_window_valid <= i_valid && (state_next == ST_RUN);
			if (i_valid)
				sample_cnt <= cnt_next;
		end
	end

	// No pulse follows a cycle without a sample.
	a_no_pulse_after_idle: assert property (@(posedge i_clk) disable iff (reset)
		!i_valid |=> !o_window_valid);

	// Running implies a fully primed count.
	a_run_primed: assert property (@(posedge i_clk) disable iff (reset)
		state == ST_RUN |-> sample_cnt == CNT_FULL);

	// Largest window total must fit the sum type.
	if (WIN_W * WIN_H * (2**PIX_W - 1) >= 2**SUM_W)
	begin : g_sum_range
		$error("integral_window: window total overflows SUM_W");
	end

endmodule

`default_nettype wire

// ==== line_row/line_row.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_row
	import haar_pkg::*;
#(
	parameter int FRAME_W = 10,
	parameter int WIN_W   = 3
)
(
	input  wire logic  i_clk,
	input  wire logic  reset,
	input  wire logic  i_accept,
	input  wire pix_t  i_pix,
	input  wire sum_t  i_col_below,
	output pix_t              o_pix_delayed,
	output sum_t              o_col_sum,
	output sum_t [WIN_W-1:0]  o_row_integral
);

	// Line delay status.
	logic fifo_full;

	// Column sum of this row and all older rows.
	sum_t col_sum;

	// Registered taps, index 0 is the oldest column.
	sum_t [WIN_W-2:0] tap_q;

	// Full tap view.
	// Newest entry is the live column sum.
	sum_t [WIN_W-1:0] taps;

	// Running sums across the taps.
	sum_t [WIN_W-1:0] prefix;

	// ~~~~~~~~~~~~~~~~~~~~
	// Line delay.
	// ~~~~~~~~~~~~~~~~~~~~

	line_fifo #(
		.FRAME_W (FRAME_W)
	) u_line (
		.i_clk   (i_clk),
		.reset   (reset),
		.i_write (i_accept),
		.i_pix   (i_pix),
		.o_pix   (o_pix_delayed),
		.o_full  (fifo_full)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Vertical sum and taps.
	// ~~~~~~~~~~~~~~~~~~~~

	// Add this row's pixel onto the older rows.
	assign col_sum   = sum_t'(i_pix) + i_col_below;
	assign o_col_sum = col_sum;

	assign taps = {col_sum, tap_q};

	// Shift toward the oldest column on each sample.
	always_ff @(posedge i_clk)
	begin
		if (reset)
			tap_q <= '0;
		else if (i_accept)
			tap_q <= taps[WIN_W-1:1];
	end

	// Horizontal prefix sums, oldest column first.
	assign prefix[0] = taps[0];
	for (genvar c = 1; c < WIN_W; c++)
	begin : g_prefix
		assign prefix[c] = prefix[c-1] + taps[c];
	end

	assign o_row_integral = prefix;

	// Taps move only with an accepted sample.
	a_taps_hold: assert property (@(posedge i_clk) disable iff (reset)
		!i_accept |=> $stable(tap_q));

	// Before the first lap the delay still returns cleared slots.
	a_unprimed_zero: assert property (@(posedge i_clk) disable iff (reset)
		!fifo_full |-> o_pix_delayed == '0);

endmodule

`default_nettype wire

// ==== line_row/line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fifo
	import haar_pkg::*;
#(
	parameter int FRAME_W = 10
)
(
	input  wire logic i_clk,
	input  wire logic reset,
	input  wire logic i_write,
	input  wire pix_t i_pix,
	output pix_t      o_pix,
	output logic      o_full
);

	// Pointer wide enough for one line.
	localparam int PTR_W = (FRAME_W > 1) ? $clog2(FRAME_W) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FRAME_W - 1);

	// Line storage.
	pix_t             mem [FRAME_W];
	logic [PTR_W-1:0] ptr;

	// Read slot is the oldest sample.
	// It is returned before this cycle overwrites it.
	assign o_pix = mem[ptr];

	// ~~~~~~~~~~~~~~~~~~~~
	// Circular write.
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clk)
	begin
		if (reset)
		begin
			ptr    <= '0;
			o_full <= 1'b0;
			// Cleared lines read as black pixels.
			for (int i = 0; i < FRAME_W; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (i_write)
		begin
			mem[ptr] <= i_pix;
			// Wrap at line end.
			if (ptr == PTR_LAST)
			begin
				ptr    <= '0;
				// First full lap done, sticky until reset.
				o_full <= 1'b1;
			end
			else
			begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	// Pointer never leaves the line.
	a_ptr_range: assert property (@(posedge i_clk) disable iff (reset)
		ptr < FRAME_W);

endmodule

`default_nettype wire

// ==== common/haar_pkg.sv ====
`default_nettype none

package haar_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Widths.
	// ~~~~~~~~~~~~~~~~~~~~

	// Camera pixel.
	localparam int PIX_W = 8;

	// Integral sum.
	// Room for 255 over up to 256 window pixels.
	localparam int SUM_W = 16;

	// ~~~~~~~~~~~~~~~~~~~~
	// Types.
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [PIX_W-1:0] pix_t;
	typedef logic [SUM_W-1:0] sum_t;

	// One input sample.
	// The sof bit marks the first pixel of a frame.
	typedef struct packed {
		logic sof;
		pix_t data;
	} pix_beat_t;

	// Priming controller states.
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_PRIME = 2'd1,
		ST_RUN   = 2'd2
	} ctl_state_t;

endpackage

`default_nettype wire
